//--- all.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/wb_map_pkg.sv
rtl/wb_frontend.sv
rtl/issue_ctrl.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/reorder_buffer.sv
rtl/ooo_backend_top.sv
verification/tb_ooo_backend.sv

//--- Makefile
# Verilator build and run of the backend testbench
VERILATOR ?= verilator
TOP       ?= tb_ooo_backend
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal and is searched for the pass line
run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_ooo_backend.sv
// Testbench with clock, reset, Wishbone tasks, LCG, reference model, checker and test sequence
`include "backend_settings.svh"

module tb_ooo_backend;
    import isa_pkg::*;
    import wb_map_pkg::*;

    localparam int ACK_TIMEOUT   = 200;   // Cycles allowed per bus transfer
    localparam int DRAIN_TIMEOUT = 400;   // Status polls allowed per drain
    localparam int RANDOM_COUNT  = 200;

    logic                clk;
    logic                rstn;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [7:0]          wb_adr;
    logic [`BK_XLEN-1:0] wb_dat_w;
    logic [`BK_XLEN-1:0] wb_dat_r;
    logic                wb_ack;

    logic [`BK_XLEN-1:0] model_regs [`BK_NUM_REGS];   // Architectural state in program order
    logic [31:0]         lcg_state;
    logic [31:0]         status;
    int                  dispatched;                   // Instructions accepted so far
    int                  checks;
    int                  mismatches;

    ooo_backend_top u_ooo_backend_top (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // Period 4
    end

    // Executes one instruction word on the model, decoded straight from the bit fields
    function automatic void ref_execute(logic [31:0] word);
        logic [2:0]  op;
        logic [3:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        op  = word[31:29];
        rd  = word[28:25];
        a   = model_regs[word[24:21]];
        b   = model_regs[word[20:17]];
        imm = {{11{word[20]}}, word[20:0]};   // 21-bit signed immediate
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + imm;
            OP_MUL:  res = a * b;     // Low 32 bits of the product
            OP_MULI: res = a * imm;
            default: res = '0;        // Not generated
        endcase
        model_regs[rd] = res;
    endfunction

    function automatic logic [31:0] enc_r(logic [2:0] op, int rd, int rs1, int rs2);
        return {op, 4'(rd), 4'(rs1), 4'(rs2), 17'd0};
    endfunction

    function automatic logic [31:0] enc_i(logic [2:0] op, int rd, int rs1, int imm);
        return {op, 4'(rd), 4'(rs1), 21'(imm)};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Random fields everywhere, opcode folded into the seven defined ones
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        logic [31:0] r;
        r          = lcg_next();
        w          = lcg_next();
        w[31:29]   = 3'((r >> 16) % 7);
        return w;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic stop_on_timeout(string what);
        $display("Timeout: %s did not complete by time %0t", what, $time);
        $display("Summary: %0d checks, %0d mismatches, 1 timeout", checks, mismatches);
        $display("TESTS FAILED");
        $finish;
    endtask

    // One bus write, inputs change on the falling edge only
    task automatic wb_write(logic [7:0] adr, logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        @(negedge clk);
        while (!wb_ack && waited < ACK_TIMEOUT) begin   // Dispatch may stall on hazards
            waited++;
            @(negedge clk);
        end
        if (wb_ack) begin
            wb_cyc = 1'b0;   // Drop before the next edge, ack lasts one cycle
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end else begin
            stop_on_timeout($sformatf("write to 0x%02h", adr));
        end
    endtask

    task automatic wb_read(logic [7:0] adr, output logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge clk);
        while (!wb_ack && waited < ACK_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (wb_ack) begin
            data   = wb_dat_r;   // Latched together with the ack
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
        end else begin
            stop_on_timeout($sformatf("read from 0x%02h", adr));
        end
    endtask

    task automatic dispatch(logic [31:0] word);
        wb_write(ADDR_DISPATCH, word);
        ref_execute(word);   // Program order equals commit order
        dispatched++;
    endtask

    // Polls until the ROB is empty and every dispatch has retired, then compares registers
    task automatic drain_and_compare(string label);
        logic [31:0] data;
        logic        drained;
        int          polls;
        drained = 1'b0;
        polls   = 0;
        while (!drained && polls < DRAIN_TIMEOUT) begin
            wb_read(ADDR_STATUS, status);
            drained = status[STAT_EMPTY_BIT] &&
                      (status[STAT_COMMITS_MSB:STAT_COMMITS_LSB] == 16'(dispatched));
            polls++;
        end
        if (drained) begin
            check_value({label, " count"}, 32'(status[STAT_COUNT_MSB:STAT_COUNT_LSB]), 32'd0);
            check_value({label, " full"}, 32'(status[STAT_FULL_BIT]), 32'd0);
            for (int r = 0; r < `BK_NUM_REGS; r++) begin
                wb_read(ADDR_REG_BASE + 8'(4 * r), data);
                check_value($sformatf("%s r%0d", label, r), data, model_regs[r]);
            end
        end else begin
            stop_on_timeout($sformatf("drain after %s", label));
        end
    endtask

    initial begin
        rstn       = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        lcg_state  = 32'd72399;
        dispatched = 0;
        checks     = 0;
        mismatches = 0;
        for (int r = 0; r < `BK_NUM_REGS; r++) model_regs[r] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // Reset state, empty ROB and zero registers
        wb_read(ADDR_STATUS, status);
        check_value("reset empty", 32'(status[STAT_EMPTY_BIT]), 32'd1);
        check_value("reset count", 32'(status[STAT_COUNT_MSB:STAT_COUNT_LSB]), 32'd0);
        drain_and_compare("reset");

        // Single ALU ops, negative immediates included
        dispatch(enc_i(OP_ADDI, 1, 0, 1234));
        dispatch(enc_i(OP_ADDI, 2, 0, -5678));
        dispatch(enc_i(OP_ADDI, 3, 0, -1));
        dispatch(enc_i(OP_ADDI, 4, 1, -1048576));   // Most negative immediate
        dispatch(enc_r(OP_ADD, 5, 1, 2));
        dispatch(enc_r(OP_SUB, 6, 1, 2));
        dispatch(enc_r(OP_AND, 7, 2, 4));
        dispatch(enc_r(OP_XOR, 8, 3, 1));
        drain_and_compare("alu");

        // Dependent chain across both units
        dispatch(enc_r(OP_MUL, 9, 1, 2));
        dispatch(enc_r(OP_ADD, 10, 9, 1));
        dispatch(enc_i(OP_MULI, 11, 10, -3));
        dispatch(enc_r(OP_SUB, 12, 11, 9));
        dispatch(enc_r(OP_MUL, 12, 12, 12));
        dispatch(enc_i(OP_ADDI, 12, 12, 7));
        drain_and_compare("chain");

        // Slow MULs ahead of quick ALU ops, then a WAW pair on r9
        dispatch(enc_r(OP_MUL, 13, 1, 2));
        dispatch(enc_i(OP_MULI, 14, 6, 1000));
        dispatch(enc_r(OP_MUL, 15, 4, 8));
        dispatch(enc_r(OP_ADD, 5, 1, 3));
        dispatch(enc_r(OP_XOR, 7, 3, 6));
        dispatch(enc_r(OP_SUB, 0, 1, 3));
        dispatch(enc_r(OP_MUL, 9, 2, 2));
        dispatch(enc_i(OP_ADDI, 9, 3, 77));
        drain_and_compare("ooo");

        // Independent burst longer than the ROB
        for (int i = 0; i < `BK_ROB_ENTRIES + 4; i++) begin
            if (i % 2 == 1) dispatch(enc_r(OP_MUL, i, 12 + i % 4, 15 - i % 4));
            else dispatch(enc_i(OP_ADDI, i, 12 + i % 4, 3 * i - 20));
        end
        drain_and_compare("burst");

        // Random program
        for (int n = 0; n < RANDOM_COUNT; n++) dispatch(random_word());
        drain_and_compare("random");

        $display("Summary: %0d checks, %0d mismatches, 0 timeouts", checks, mismatches);
        if (mismatches == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/ooo_backend_top.sv
// Top level of the backend with frontend, issue, ALU, multiplier and ROB
`include "backend_settings.svh"

module ooo_backend_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  wb_map_pkg::wb_addr_t  wb_adr_i,
    input  logic [`BK_XLEN-1:0]   wb_dat_i,
    output logic [`BK_XLEN-1:0]   wb_dat_o,
    output logic                  wb_ack_o
);
    import isa_pkg::*;
    import wb_map_pkg::*;

    logic disp_valid, disp_ready;
    instr_word_t disp_word;
    logic [`BK_REG_AW-1:0] rd_addr, alloc_rd, commit_rd;
    logic [`BK_XLEN-1:0] rd_data, status_word, opa, opb, commit_data;
    logic [`BK_XLEN-1:0] alu_data, mul_data;
    logic alloc_valid, alu_valid, mul_valid, alu_wb_valid, mul_wb_valid;
    logic rob_full, rob_empty, commit_valid;
    logic [`BK_ROB_AW-1:0] rob_tail, tag, alu_tag, mul_tag;
    logic [`BK_ROB_AW:0] rob_count;
    logic [15:0] commit_total;
    opcode_t op;

    // Status word for the host
    always_comb begin
        status_word = '0;
        status_word[STAT_COUNT_MSB:STAT_COUNT_LSB]     = rob_count;
        status_word[STAT_EMPTY_BIT]                    = rob_empty;
        status_word[STAT_FULL_BIT]                     = rob_full;
        status_word[STAT_COMMITS_MSB:STAT_COMMITS_LSB] = commit_total;
    end

    wb_frontend u_wb_frontend (.clk_i, .rstn_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i,
        .wb_dat_i, .wb_dat_o, .wb_ack_o, .disp_valid_o(disp_valid), .disp_ready_i(disp_ready),
        .disp_word_o(disp_word), .rd_addr_o(rd_addr), .rd_data_i(rd_data),
        .status_i(status_word));

    issue_ctrl u_issue_ctrl (.clk_i, .rstn_i, .disp_valid_i(disp_valid), .disp_word_i(disp_word),
        .disp_ready_o(disp_ready), .rob_full_i(rob_full), .rob_tail_i(rob_tail),
        .alloc_valid_o(alloc_valid), .alloc_rd_o(alloc_rd), .alu_valid_o(alu_valid),
        .mul_valid_o(mul_valid), .op_o(op), .opa_o(opa), .opb_o(opb), .tag_o(tag),
        .commit_valid_i(commit_valid), .commit_rd_i(commit_rd), .commit_data_i(commit_data),
        .rd_addr_i(rd_addr), .rd_data_o(rd_data));

    alu_unit u_alu_unit (.clk_i, .rstn_i, .valid_i(alu_valid), .op_i(op), .opa_i(opa),
        .opb_i(opb), .tag_i(tag), .wb_valid_o(alu_wb_valid), .wb_tag_o(alu_tag),
        .wb_data_o(alu_data));

    mul_unit u_mul_unit (.clk_i, .rstn_i, .valid_i(mul_valid), .opa_i(opa), .opb_i(opb),
        .tag_i(tag), .wb_valid_o(mul_wb_valid), .wb_tag_o(mul_tag), .wb_data_o(mul_data));

    reorder_buffer u_reorder_buffer (.clk_i, .rstn_i, .alloc_valid_i(alloc_valid),
        .alloc_rd_i(alloc_rd), .tail_o(rob_tail), .full_o(rob_full), .empty_o(rob_empty),
        .count_o(rob_count), .wb0_valid_i(alu_wb_valid), .wb0_tag_i(alu_tag),
        .wb0_data_i(alu_data), .wb1_valid_i(mul_wb_valid), .wb1_tag_i(mul_tag),
        .wb1_data_i(mul_data), .commit_valid_o(commit_valid), .commit_rd_o(commit_rd),
        .commit_data_o(commit_data), .commit_total_o(commit_total));

endmodule

//--- rtl/reorder_buffer.sv
// Circular reorder buffer, two writeback ports, in-order commit
`include "backend_settings.svh"

module reorder_buffer (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   alloc_valid_i,
    input  logic [`BK_REG_AW-1:0]  alloc_rd_i,
    output logic [`BK_ROB_AW-1:0]  tail_o,        // Index of the next allocation
    output logic                   full_o,
    output logic                   empty_o,
    output logic [`BK_ROB_AW:0]    count_o,
    input  logic                   wb0_valid_i,   // ALU port
    input  logic [`BK_ROB_AW-1:0]  wb0_tag_i,
    input  logic [`BK_XLEN-1:0]    wb0_data_i,
    input  logic                   wb1_valid_i,   // Multiplier port
    input  logic [`BK_ROB_AW-1:0]  wb1_tag_i,
    input  logic [`BK_XLEN-1:0]    wb1_data_i,
    output logic                   commit_valid_o,
    output logic [`BK_REG_AW-1:0]  commit_rd_o,
    output logic [`BK_XLEN-1:0]    commit_data_o,
    output logic [15:0]            commit_total_o
);
    localparam int ENTRIES = `BK_ROB_ENTRIES;

    // Entry state, control bits reset, payload not
    logic [ENTRIES-1:0]    ent_valid;
    logic [ENTRIES-1:0]    ent_done;
    logic [`BK_REG_AW-1:0] ent_rd   [ENTRIES];
    logic [`BK_XLEN-1:0]   ent_data [ENTRIES];

    logic [`BK_ROB_AW-1:0] head;
    logic [`BK_ROB_AW-1:0] tail;
    logic [`BK_ROB_AW:0]   count;   // One bit wider than the index
    logic                  retire;

    assign retire  = ent_valid[head] & ent_done[head];
    assign full_o  = (count == ENTRIES);
    assign empty_o = (count == 0);
    assign count_o = count;
    assign tail_o  = tail;

    assign commit_valid_o = retire;
    assign commit_rd_o    = ent_rd[head];
    assign commit_data_o  = ent_data[head];

    // Queue pointers and retire counter
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            commit_total_o <= '0;
        end else begin
            tail  <= tail + alloc_valid_i;   // Wraps at the power-of-two depth
            head  <= head + retire;
            count <= count + alloc_valid_i - retire;
            if (retire) commit_total_o <= commit_total_o + 16'd1;
        end
    end

    // Valid and done flags, indices never collide within a cycle
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ent_valid <= '0;
            ent_done  <= '0;
        end else begin
            if (alloc_valid_i) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= 1'b0;
            end
            if (wb0_valid_i) ent_done[wb0_tag_i] <= 1'b1;
            if (wb1_valid_i) ent_done[wb1_tag_i] <= 1'b1;
            if (retire) ent_valid[head] <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_valid_i) ent_rd[tail] <= alloc_rd_i;
        if (wb0_valid_i) ent_data[wb0_tag_i] <= wb0_data_i;
        if (wb1_valid_i) ent_data[wb1_tag_i] <= wb1_data_i;
    end

    // Issue side must respect the full flag
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        alloc_valid_i |-> !full_o);
    // Units only complete live entries, once each
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb0_valid_i |-> (ent_valid[wb0_tag_i] && !ent_done[wb0_tag_i]));
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb1_valid_i |-> (ent_valid[wb1_tag_i] && !ent_done[wb1_tag_i]));

endmodule

//--- rtl/mul_unit.sv
// Pipelined multiplier, one issue per cycle, ROB tag per stage
`include "backend_settings.svh"

module mul_unit (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   valid_i,
    input  logic [`BK_XLEN-1:0]    opa_i,
    input  logic [`BK_XLEN-1:0]    opb_i,
    input  logic [`BK_ROB_AW-1:0]  tag_i,
    output logic                   wb_valid_o,
    output logic [`BK_ROB_AW-1:0]  wb_tag_o,
    output logic [`BK_XLEN-1:0]    wb_data_o
);
    localparam int STAGES = `BK_MUL_STAGES;

    logic [STAGES-1:0]    vld_q;
    logic [`BK_ROB_AW-1:0] tag_q  [STAGES];
    logic [`BK_XLEN-1:0]  prod_q [STAGES];
    logic [`BK_XLEN-1:0]  prod;

    assign prod = opa_i * opb_i;   // Low word only

    // Valid shift
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[STAGES-2:0], valid_i};
        end
    end

    // Tag and product follow the valid bits
    always_ff @(posedge clk_i) begin
        tag_q[0]  <= tag_i;
        prod_q[0] <= prod;
        for (int s = 1; s < STAGES; s++) begin
            tag_q[s]  <= tag_q[s-1];
            prod_q[s] <= prod_q[s-1];
        end
    end

    assign wb_valid_o = vld_q[STAGES-1];
    assign wb_tag_o   = tag_q[STAGES-1];
    assign wb_data_o  = prod_q[STAGES-1];

    // Fixed latency, nothing dropped or duplicated in flight
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_valid_o == $past(valid_i, `BK_MUL_STAGES));

endmodule

//--- rtl/alu_unit.sv
// Single-cycle ALU for add, sub, and, xor and add-immediate
`include "backend_settings.svh"

module alu_unit (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   valid_i,
    input  isa_pkg::opcode_t       op_i,
    input  logic [`BK_XLEN-1:0]    opa_i,
    input  logic [`BK_XLEN-1:0]    opb_i,
    input  logic [`BK_ROB_AW-1:0]  tag_i,
    output logic                   wb_valid_o,
    output logic [`BK_ROB_AW-1:0]  wb_tag_o,
    output logic [`BK_XLEN-1:0]    wb_data_o
);
    import isa_pkg::*;

    logic [`BK_XLEN-1:0] result;

    always_comb begin
        case (op_i)
            OP_ADD, OP_ADDI: result = opa_i + opb_i;   // Operand b already holds imm
            OP_SUB:          result = opa_i - opb_i;
            OP_AND:          result = opa_i & opb_i;
            OP_XOR:          result = opa_i ^ opb_i;
            default:         result = '0;              // MUL ops never routed here
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= valid_i;
        end
    end

    // Result and tag ride along with the valid
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wb_tag_o  <= tag_i;
            wb_data_o <= result;
        end
    end

endmodule

//--- rtl/issue_ctrl.sv
// Register file, busy-bit scoreboard, operand read and in-order issue
`include "backend_settings.svh"

module issue_ctrl (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   disp_valid_i,
    input  isa_pkg::instr_word_t   disp_word_i,
    output logic                   disp_ready_o,
    input  logic                   rob_full_i,
    input  logic [`BK_ROB_AW-1:0]  rob_tail_i,     // Index granted to this instruction
    output logic                   alloc_valid_o,
    output logic [`BK_REG_AW-1:0]  alloc_rd_o,
    output logic                   alu_valid_o,
    output logic                   mul_valid_o,
    output isa_pkg::opcode_t       op_o,
    output logic [`BK_XLEN-1:0]    opa_o,
    output logic [`BK_XLEN-1:0]    opb_o,
    output logic [`BK_ROB_AW-1:0]  tag_o,
    input  logic                   commit_valid_i,
    input  logic [`BK_REG_AW-1:0]  commit_rd_i,
    input  logic [`BK_XLEN-1:0]    commit_data_i,
    input  logic [`BK_REG_AW-1:0]  rd_addr_i,      // Host read port
    output logic [`BK_XLEN-1:0]    rd_data_o
);
    import isa_pkg::*;

    logic [`BK_XLEN-1:0]     regs [`BK_NUM_REGS];
    logic [`BK_NUM_REGS-1:0] busy;   // Pending writer in the ROB

    opcode_t             op;
    logic [3:0]          rd, rs1, rs2;
    logic                use_imm;
    logic                hazard;
    logic                fire;
    logic [`BK_XLEN-1:0] imm_ext;

    // Both views share opcode, rd and rs1
    assign op      = disp_word_i.r_view.opcode;
    assign rd      = disp_word_i.r_view.rd;
    assign rs1     = disp_word_i.r_view.rs1;
    assign rs2     = disp_word_i.r_view.rs2;
    assign use_imm = is_imm(op);
    assign imm_ext = {{(`BK_XLEN-21){disp_word_i.i_view.imm[20]}}, disp_word_i.i_view.imm};

    // No forwarding, so wait for RAW and WAW producers to commit
    assign hazard       = busy[rs1] | busy[rd] | (~use_imm & busy[rs2]);
    assign disp_ready_o = ~rob_full_i & ~hazard;
    assign fire         = disp_valid_i & disp_ready_o;

    assign alloc_valid_o = fire;
    assign alloc_rd_o    = rd;
    assign rd_data_o     = regs[rd_addr_i];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy        <= '0;
            alu_valid_o <= 1'b0;
            mul_valid_o <= 1'b0;
            for (int i = 0; i < `BK_NUM_REGS; i++) regs[i] <= '0;
        end else begin
            alu_valid_o <= fire & ~is_mul(op);
            mul_valid_o <= fire & is_mul(op);
            if (commit_valid_i) begin
                regs[commit_rd_i] <= commit_data_i;   // In-order retire
                busy[commit_rd_i] <= 1'b0;
            end
            if (fire) busy[rd] <= 1'b1;   // Never the committing rd, it is busy
        end
    end

    // Issue payload, qualified by the strobes
    always_ff @(posedge clk_i) begin
        if (fire) begin
            op_o  <= op;
            opa_o <= regs[rs1];
            opb_o <= use_imm ? imm_ext : regs[rs2];
            tag_o <= rob_tail_i;
        end
    end

    // Issue only follows an allocation into a ROB that had room
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (alu_valid_o || mul_valid_o) |-> $past(!rob_full_i));
    // ROB retires only registers the scoreboard holds busy
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_valid_i |-> busy[commit_rd_i]);

endmodule

//--- rtl/wb_frontend.sv
// Wishbone classic slave, dispatch requests and register/status reads
`include "backend_settings.svh"

module wb_frontend (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  wb_map_pkg::wb_addr_t   wb_adr_i,
    input  logic [`BK_XLEN-1:0]    wb_dat_i,
    output logic [`BK_XLEN-1:0]    wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   disp_valid_o,   // Pending dispatch write
    input  logic                   disp_ready_i,
    output isa_pkg::instr_word_t   disp_word_o,
    output logic [`BK_REG_AW-1:0]  rd_addr_o,      // Register file read port
    input  logic [`BK_XLEN-1:0]    rd_data_i,
    input  logic [`BK_XLEN-1:0]    status_i
);
    import wb_map_pkg::*;

    logic                req;
    logic                hit_disp;
    logic                served_q;       // Set once acked, until stb drops
    logic [`BK_XLEN-1:0] rd_mux;

    assign req      = wb_cyc_i & wb_stb_i & ~served_q;
    assign hit_disp = req & wb_we_i & (wb_adr_i == ADDR_DISPATCH);

    assign disp_valid_o = hit_disp;   // Held while the master waits
    assign disp_word_o  = wb_dat_i;
    assign rd_addr_o    = wb_adr_i[`BK_REG_AW+1:2];   // Word index inside register window

    // Read source select
    always_comb begin
        rd_mux = '0;
        if (wb_adr_i == ADDR_STATUS) begin
            rd_mux = status_i;
        end else if ((wb_adr_i & ADDR_REG_MASK) == ADDR_REG_BASE) begin
            rd_mux = rd_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_ack_o <= 1'b0;
            served_q <= 1'b0;
        end else begin
            if (hit_disp) begin
                wb_ack_o <= disp_ready_i;   // Stalls until issue accepts
                served_q <= disp_ready_i;
            end else if (req) begin
                wb_ack_o <= 1'b1;           // Reads and ignored writes
                served_q <= 1'b1;
            end else begin
                wb_ack_o <= 1'b0;
                if (!(wb_cyc_i && wb_stb_i)) served_q <= 1'b0;   // Cycle closed
            end
        end
    end

    // Read data latched with the ack
    always_ff @(posedge clk_i) begin
        if (req && !wb_we_i) wb_dat_o <= rd_mux;
    end

endmodule

//--- rtl/wb_map_pkg.sv
// Wishbone address map and status word field positions
package wb_map_pkg;

    typedef logic [7:0] wb_addr_t;

    localparam wb_addr_t ADDR_DISPATCH = 8'h00;   // Write only, instruction word
    localparam wb_addr_t ADDR_STATUS   = 8'h04;   // Read only
    localparam wb_addr_t ADDR_REG_BASE = 8'h40;   // r at base + 4*r
    localparam wb_addr_t ADDR_REG_MASK = 8'hC0;   // Window select bits

    // Status word layout
    localparam int STAT_COUNT_LSB   = 0;
    localparam int STAT_COUNT_MSB   = 3;
    localparam int STAT_EMPTY_BIT   = 4;
    localparam int STAT_FULL_BIT    = 5;
    localparam int STAT_COMMITS_LSB = 16;
    localparam int STAT_COMMITS_MSB = 31;

endpackage

//--- rtl/isa_pkg.sv
// Opcodes, R/I instruction word union and decode helpers
package isa_pkg;

    typedef logic [2:0] opcode_t;

    localparam opcode_t OP_ADD  = 3'd0;
    localparam opcode_t OP_SUB  = 3'd1;
    localparam opcode_t OP_AND  = 3'd2;
    localparam opcode_t OP_XOR  = 3'd3;
    localparam opcode_t OP_ADDI = 3'd4;   // Add path with immediate
    localparam opcode_t OP_MUL  = 3'd5;
    localparam opcode_t OP_MULI = 3'd6;

    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [16:0] unused;   // Ignored by decode
    } r_type_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [20:0] imm;      // Signed immediate
    } i_type_t;

    // Same 32-bit word, two decodings
    typedef union packed {
        r_type_t r_view;
        i_type_t i_view;
    } instr_word_t;

    function automatic logic is_imm(opcode_t op);
        return (op == OP_ADDI) || (op == OP_MULI);
    endfunction

    function automatic logic is_mul(opcode_t op);
        return (op == OP_MUL) || (op == OP_MULI);
    endfunction

endpackage

//--- rtl/backend_settings.svh
// Size and latency macros of the execution backend
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// Datapath and register file
`define BK_XLEN         32
`define BK_NUM_REGS     16
`define BK_REG_AW       $clog2(`BK_NUM_REGS)

// Reorder buffer depth, power of two
`define BK_ROB_ENTRIES  8
`define BK_ROB_AW       $clog2(`BK_ROB_ENTRIES)

// Multiplier pipeline latency in cycles
`define BK_MUL_STAGES   3

`endif
